//--- quant_defines.svh
`ifndef QUANT_DEFINES_SVH
`define QUANT_DEFINES_SVH

//////////////////////////////////////////////////////////////////////////////
// lane geometry and pixel widths
//////////////////////////////////////////////////////////////////////////////

// pixels per channel half
`define QT_LANES        8
`define QT_PIX_W_88     24
`define QT_PIX_W_18     16
// 16 bit times 2 halves times lanes
`define QT_ROW_W        256

// multiplier operand and product widths
`define QT_MULT_A_W     24
`define QT_MULT_B_W     16
`define QT_MULT_P_W     40

// scale set fields and quantized output
`define QT_TAIL_W       16
`define QT_RANK_W       8
`define QT_Q_W          8

// scale table size
`define QT_TABLE_DEPTH  16
`define QT_TABLE_AW     4

// full row widths over both channel halves
`define QT_A_ROW_W      (`QT_MULT_A_W * 2 * `QT_LANES)
`define QT_B_ROW_W      (`QT_MULT_B_W * 2 * `QT_LANES)
`define QT_P_ROW_W      (`QT_MULT_P_W * 2 * `QT_LANES)
`define QT_Q_ROW_W      (`QT_Q_W * 2 * `QT_LANES)

`endif

//--- quant_pkg.sv
`include "quant_defines.svh"

package quant_pkg;

    //////////////////////////////////////////////////////////////////////////////
    // pixel mode
    //////////////////////////////////////////////////////////////////////////////

    // 88 carries one channel of 24 bit pixels
    // 18 carries two channels of 16 bit pixels
    typedef enum logic [0:0] {
        MODE_88 = 1'b0,
        MODE_18 = 1'b1
    } mode_e;

    //////////////////////////////////////////////////////////////////////////////
    // scale set
    //////////////////////////////////////////////////////////////////////////////

    // lo fields serve the lower lane half
    // hi fields serve the upper half, mode 18 only
    // 48 bits in all
    typedef struct packed {
        // fixed point multipliers
        logic [`QT_TAIL_W-1:0] tail_hi;
        logic [`QT_TAIL_W-1:0] tail_lo;
        // right shift amounts applied to the products
        logic [`QT_RANK_W-1:0] rank_hi;
        logic [`QT_RANK_W-1:0] rank_lo;
    } scale_set_t;

endpackage

//--- scale_table.sv
`timescale 1ns/1ns
`include "quant_defines.svh"

module scale_table import quant_pkg::*; (
    input  logic                    clk,
    input  logic                    e_tail_reset,
    // write side, one entry per strobe
    input  logic                    tbl_we,
    input  logic [`QT_TABLE_AW-1:0] tbl_waddr,
    input  logic [`QT_TAIL_W-1:0]   tbl_tail_lo,
    input  logic [`QT_TAIL_W-1:0]   tbl_tail_hi,
    input  logic [`QT_RANK_W-1:0]   tbl_rank_lo,
    input  logic [`QT_RANK_W-1:0]   tbl_rank_hi,
    // read side, presented one cycle ahead of the row
    input  logic [`QT_TABLE_AW-1:0] sel_index,
    output scale_set_t              sel_set
);

    // entry storage
    scale_set_t entry_q [`QT_TABLE_DEPTH];

    // incoming fields packed into one set
    scale_set_t wr_set;

    //////////////////////////////////////////////////////////////////////////////
    // write port
    //////////////////////////////////////////////////////////////////////////////

    assign wr_set.tail_lo = tbl_tail_lo;
    assign wr_set.tail_hi = tbl_tail_hi;
    assign wr_set.rank_lo = tbl_rank_lo;
    assign wr_set.rank_hi = tbl_rank_hi;

    // whole table starts at zero so an unwritten index scales to 0
    always_ff @(posedge clk) begin
        if (e_tail_reset) begin
            for (int i = 0; i < `QT_TABLE_DEPTH; i++) begin
                entry_q[i] <= '0;
            end
        end else if (tbl_we) begin
            entry_q[tbl_waddr] <= wr_set;
        end
    end

    //////////////////////////////////////////////////////////////////////////////
    // read port
    //////////////////////////////////////////////////////////////////////////////

    // combinational lookup
    // e_scale registers it at the edge ending the select cycle
    // a write in the same cycle shows up on the next lookup only
    assign sel_set = entry_q[sel_index];

    //////////////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////////////

    // the clear loop owns the table during reset
    // a write strobe there would be dropped without notice
    a_no_write_in_reset: assert property (
        @(posedge clk) e_tail_reset |-> !tbl_we
    ) else $error("scale_table: write strobe during reset, addr %0h", tbl_waddr);

endmodule

//--- e_scale.sv
`timescale 1ns/1ns
`include "quant_defines.svh"

module e_scale import quant_pkg::*; (
    input  logic                   clk,
    input  logic                   e_tail_reset,
    input  logic                   mode_init,
    // cycle t-1
    input  scale_set_t             scale_set,
    // cycle t
    input  logic [`QT_ROW_W-1:0]   bias_row,
    output logic [`QT_A_ROW_W-1:0] a_row,
    output logic [`QT_B_ROW_W-1:0] b_row,
    // cycle t+1
    input  logic [`QT_P_ROW_W-1:0] p_row,
    output logic [`QT_Q_ROW_W-1:0] q_row
);

    localparam int LANES      = `QT_LANES;
    localparam int HALF_ROW_W = `QT_ROW_W / 2;
    localparam int A_W        = `QT_MULT_A_W;
    localparam int B_W        = `QT_MULT_B_W;
    localparam int P_W        = `QT_MULT_P_W;
    localparam int Q_W        = `QT_Q_W;
    // useful product bits per mode
    localparam int PROD_W_88  = `QT_PIX_W_88 + `QT_TAIL_W;
    localparam int PROD_W_18  = `QT_PIX_W_18 + `QT_TAIL_W;

    mode_e mode;

    // first stage, tails used in cycle t
    scale_set_t set_d1;
    // second stage, ranks line up with the product in t+1
    logic [`QT_RANK_W-1:0] rank_lo_d2;
    logic [`QT_RANK_W-1:0] rank_hi_d2;

    //////////////////////////////////////////////////////////////////////////////
    // mode latch and scale pipeline
    //////////////////////////////////////////////////////////////////////////////

    // mode follows mode_init for as long as reset is held
    always_ff @(posedge clk) begin
        if (e_tail_reset) begin
            mode <= mode_e'(mode_init);
        end
    end

    always_ff @(posedge clk) begin
        if (e_tail_reset) begin
            set_d1     <= '0;
            rank_lo_d2 <= '0;
            rank_hi_d2 <= '0;
        end else begin
            set_d1     <= scale_set;
            rank_lo_d2 <= set_d1.rank_lo;
            rank_hi_d2 <= set_d1.rank_hi;
        end
    end

    // trim the product to the mode width, shift, then apply the relu fix
    function automatic logic [Q_W-1:0] requant(
        input logic [P_W-1:0]        prod,
        input mode_e                 m,
        input logic [`QT_RANK_W-1:0] rank
    );
        logic [P_W-1:0] kept;
        logic [P_W-1:0] shifted;
        kept = '0;
        if (m == MODE_88) begin
            kept[PROD_W_88-1:0] = prod[PROD_W_88-1:0];
        end else begin
            kept[PROD_W_18-1:0] = prod[PROD_W_18-1:0];
        end
        // logical shift, large ranks simply flush to zero
        shifted = kept >> rank;
        // top bit of the 8 bit window set means the value clamps to 0
        if (shifted[Q_W-1]) begin
            return '0;
        end
        return shifted[Q_W-1:0];
    endfunction

    //////////////////////////////////////////////////////////////////////////////
    // per lane operands and requantization
    //////////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        // index of the matching lane in the upper half
        localparam int HI = LANES + i;

        logic [`QT_PIX_W_88-1:0] pix_88;
        logic [`QT_PIX_W_18-1:0] pix_lo;
        logic [`QT_PIX_W_18-1:0] pix_hi;

        // mode 88 pixels pack from bit 0 at 24 bits each
        assign pix_88 = bias_row[i*`QT_PIX_W_88 +: `QT_PIX_W_88];
        // mode 18 splits the row into two 16 bit channels
        assign pix_lo = bias_row[i*`QT_PIX_W_18 +: `QT_PIX_W_18];
        assign pix_hi = bias_row[HALF_ROW_W + i*`QT_PIX_W_18 +: `QT_PIX_W_18];

        // cycle t
        // lower half, operand A by mode
        assign a_row[i*A_W +: A_W] = (mode == MODE_88) ? A_W'(pix_88) : A_W'(pix_lo);
        // upper half carries nothing in mode 88
        assign a_row[HI*A_W +: A_W] = (mode == MODE_18) ? A_W'(pix_hi) : '0;

        // lower tail serves both modes
        assign b_row[i*B_W +: B_W] = B_W'(set_d1.tail_lo);
        assign b_row[HI*B_W +: B_W] = (mode == MODE_18) ? B_W'(set_d1.tail_hi) : '0;

        // cycle t+1
        assign q_row[i*Q_W +: Q_W] = requant(p_row[i*P_W +: P_W], mode, rank_lo_d2);
        assign q_row[HI*Q_W +: Q_W] = (mode == MODE_18) ?
            requant(p_row[HI*P_W +: P_W], MODE_18, rank_hi_d2) : '0;
    end

    //////////////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////////////

    // rows in flight were set up under the latched mode
    // a change outside reset would mix operand and product layouts
    a_mode_stable: assert property (
        @(posedge clk) !e_tail_reset |=> mode == $past(mode)
    ) else $error("e_scale: pixel mode changed outside reset");

endmodule

//--- mult_row.sv
`timescale 1ns/1ns
`include "quant_defines.svh"

module mult_row (
    input  logic                   clk,
    // cycle t operands from e_scale
    input  logic [`QT_A_ROW_W-1:0] a_row,
    input  logic [`QT_B_ROW_W-1:0] b_row,
    // cycle t+1 products back to e_scale
    output logic [`QT_P_ROW_W-1:0] p_row
);

    localparam int A_W   = `QT_MULT_A_W;
    localparam int B_W   = `QT_MULT_B_W;
    localparam int P_W   = `QT_MULT_P_W;
    // both channel halves
    localparam int N_MUL = 2 * `QT_LANES;

    //////////////////////////////////////////////////////////////////////////////
    // multiplier lanes
    //////////////////////////////////////////////////////////////////////////////

    // stands in for the shared multiplier array
    // every lane is an unsigned A times B with one register on the product
    for (genvar i = 0; i < N_MUL; i++) begin : g_mult
        logic [A_W-1:0] a;
        logic [B_W-1:0] b;
        // registered product
        logic [P_W-1:0] p_q;

        assign a = a_row[i*A_W +: A_W];
        assign b = b_row[i*B_W +: B_W];

        // 24 x 16 fills the 40 bit product exactly
        always_ff @(posedge clk) begin
            p_q <= P_W'(a) * P_W'(b);
        end

        assign p_row[i*P_W +: P_W] = p_q;
    end

endmodule

//--- requant_top.sv
`timescale 1ns/1ns
`include "quant_defines.svh"

module requant_top import quant_pkg::*; (
    input  logic                    clk,
    input  logic                    e_tail_reset,
    input  logic                    mode_init,
    // scale table writes
    input  logic                    tbl_we,
    input  logic [`QT_TABLE_AW-1:0] tbl_waddr,
    input  logic [`QT_TAIL_W-1:0]   tbl_tail_lo,
    input  logic [`QT_TAIL_W-1:0]   tbl_tail_hi,
    input  logic [`QT_RANK_W-1:0]   tbl_rank_lo,
    input  logic [`QT_RANK_W-1:0]   tbl_rank_hi,
    // scale set select, one cycle ahead of the row
    input  logic [`QT_TABLE_AW-1:0] sel_index,
    // bias row in
    input  logic [`QT_ROW_W-1:0]    bias_row,
    input  logic                    in_valid,
    // quantized row out, two cycles after in_valid
    output logic [`QT_Q_ROW_W-1:0]  out_row,
    output logic                    out_valid
);

    scale_set_t              sel_set;
    logic [`QT_A_ROW_W-1:0]  a_row;
    logic [`QT_B_ROW_W-1:0]  b_row;
    logic [`QT_P_ROW_W-1:0]  p_row;
    logic [`QT_Q_ROW_W-1:0]  q_row;
    // valid beside the product stage
    logic                    valid_d1;

    //////////////////////////////////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////////////////////////////////

    scale_table u_scale_table (
        .clk          (clk),
        .e_tail_reset (e_tail_reset),
        .tbl_we       (tbl_we),
        .tbl_waddr    (tbl_waddr),
        .tbl_tail_lo  (tbl_tail_lo),
        .tbl_tail_hi  (tbl_tail_hi),
        .tbl_rank_lo  (tbl_rank_lo),
        .tbl_rank_hi  (tbl_rank_hi),
        .sel_index    (sel_index),
        .sel_set      (sel_set)
    );

    e_scale u_e_scale (
        .clk          (clk),
        .e_tail_reset (e_tail_reset),
        .mode_init    (mode_init),
        .scale_set    (sel_set),
        .bias_row     (bias_row),
        .a_row        (a_row),
        .b_row        (b_row),
        .p_row        (p_row),
        .q_row        (q_row)
    );

    // products come back to e_scale one cycle later
    mult_row u_mult_row (
        .clk   (clk),
        .a_row (a_row),
        .b_row (b_row),
        .p_row (p_row)
    );

    //////////////////////////////////////////////////////////////////////////////
    // valid pipe and output register
    //////////////////////////////////////////////////////////////////////////////

    // no back-pressure, so each row advances every cycle
    // idle cycles leave out_row at zero
    always_ff @(posedge clk) begin
        if (e_tail_reset) begin
            valid_d1  <= 1'b0;
            out_valid <= 1'b0;
            out_row   <= '0;
        end else begin
            valid_d1  <= in_valid;
            out_valid <= valid_d1;
            out_row   <= valid_d1 ? q_row : '0;
        end
    end

    //////////////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////////////

    a_idle_row_zero: assert property (
        @(posedge clk) disable iff (e_tail_reset) !out_valid |-> out_row == '0
    ) else $error("requant_top: out_row nonzero while out_valid is low");

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    // half of the 4 ns period
    parameter int HALF_PERIOD = 2
) (
    output logic clk
);

    // free running, starts low so the first rising edge lands at 2 ns
    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule

//--- tb_requant_top.sv
`timescale 1ns/1ns
`include "quant_defines.svh"

module tb_requant_top import quant_pkg::*; ();

    // rows per burst, sent on consecutive cycles
    localparam int BURST_LEN = 4;
    localparam int N_BURSTS = 6;
    localparam int CLAMP_IDX = 15;
    localparam int REWRITE_IDX = 3;
    // per pass reset, table fill plus three single writes, random plus three extra bursts
    localparam int RESET_CYC = 2;
    localparam int WRITE_CYC = `QT_TABLE_DEPTH + 3;
    localparam int ROW_CYC = (N_BURSTS + 3) * (BURST_LEN + 3);
    localparam int CYCLE_LIMIT = 2 * (RESET_CYC + WRITE_CYC + ROW_CYC) + 50;

    logic                    clk;
    logic                    e_tail_reset;
    logic                    mode_init;
    logic                    tbl_we;
    logic [`QT_TABLE_AW-1:0] tbl_waddr;
    logic [`QT_TAIL_W-1:0]   tbl_tail_lo;
    logic [`QT_TAIL_W-1:0]   tbl_tail_hi;
    logic [`QT_RANK_W-1:0]   tbl_rank_lo;
    logic [`QT_RANK_W-1:0]   tbl_rank_hi;
    logic [`QT_TABLE_AW-1:0] sel_index;
    logic [`QT_ROW_W-1:0]    bias_row;
    logic                    in_valid;
    logic [`QT_Q_ROW_W-1:0]  out_row;
    logic                    out_valid;

    // reference model state
    scale_set_t model_tbl [`QT_TABLE_DEPTH];
    mode_e      model_mode;
    logic [`QT_Q_ROW_W-1:0] exp_q [$];
    logic [`QT_Q_ROW_W-1:0] mask_q [$];
    // expected output stage, two cycles behind in_valid
    logic                   exp_v1;
    logic                   exp_v2;
    logic [`QT_Q_ROW_W-1:0] exp_row2;
    logic [`QT_Q_ROW_W-1:0] exp_mask2;

    // burst buffers filled before each run_burst
    logic [`QT_TABLE_AW-1:0] burst_idx [BURST_LEN];
    logic [`QT_ROW_W-1:0]    burst_row [BURST_LEN];

    int clamp_hits = 0;
    int rows_sent = 0;
    int cycle_count = 0;

    tb_clock_gen u_clock_gen (.clk(clk));

    requant_top UUT (
        .clk          (clk),
        .e_tail_reset (e_tail_reset),
        .mode_init    (mode_init),
        .tbl_we       (tbl_we),
        .tbl_waddr    (tbl_waddr),
        .tbl_tail_lo  (tbl_tail_lo),
        .tbl_tail_hi  (tbl_tail_hi),
        .tbl_rank_lo  (tbl_rank_lo),
        .tbl_rank_hi  (tbl_rank_hi),
        .sel_index    (sel_index),
        .bias_row     (bias_row),
        .in_valid     (in_valid),
        .out_row      (out_row),
        .out_valid    (out_valid)
    );

    ////////////////////////////////////////////////////////////////////////////
    // failure reporting
    ////////////////////////////////////////////////////////////////////////////

    task automatic fail_mismatch(input string name, input logic [`QT_Q_ROW_W:0] got,
                                 input logic [`QT_Q_ROW_W:0] want);
        $display("MISMATCH %s got %0h expected %0h", name, got, want);
        $display("TEST FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic fail_plain(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "stopping at first error");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    // one lane keeps the mode width, shifts, then clamps on bit 7
    // bit 8 of the result flags a clamped lane
    function automatic logic [8:0] quant_lane(input logic [39:0] prod, input int keep_w,
                                              input logic [7:0] rank);
        logic [39:0] kept;
        logic [39:0] shifted;
        kept = prod;
        if (keep_w < 40) begin
            kept = prod & ((40'd1 << keep_w) - 40'd1);
        end
        shifted = kept >> rank;
        return {shifted[7], shifted[7] ? 8'h00 : shifted[7:0]};
    endfunction

    task automatic push_expected(input logic [255:0] row, input scale_set_t s);
        logic [127:0] q;
        logic [127:0] mask;
        logic [8:0]   r_lo;
        logic [8:0]   r_hi;
        q = '0;
        mask = '0;
        for (int i = 0; i < `QT_LANES; i++) begin
            if (model_mode == MODE_88) begin
                r_lo = quant_lane(40'(row[i*24 +: 24]) * 40'(s.tail_lo), 40, s.rank_lo);
                // upper half stays zero in this mode
                r_hi = '0;
            end else begin
                r_lo = quant_lane(40'(row[i*16 +: 16]) * 40'(s.tail_lo), 32, s.rank_lo);
                r_hi = quant_lane(40'(row[128 + i*16 +: 16]) * 40'(s.tail_hi), 32, s.rank_hi);
            end
            q[i*8 +: 8] = r_lo[7:0];
            q[(8+i)*8 +: 8] = r_hi[7:0];
            if (r_lo[8]) begin
                mask[i*8 +: 8] = 8'hff;
                clamp_hits++;
            end
            if (r_hi[8]) begin
                mask[(8+i)*8 +: 8] = 8'hff;
                clamp_hits++;
            end
        end
        exp_q.push_back(q);
        mask_q.push_back(mask);
        rows_sent++;
    endtask

    // fixed two cycle latency, rows leave in the order they came
    always @(posedge clk) begin
        if (e_tail_reset) begin
            exp_v1    <= 1'b0;
            exp_v2    <= 1'b0;
            exp_row2  <= '0;
            exp_mask2 <= '0;
        end else begin
            exp_v1 <= in_valid;
            exp_v2 <= exp_v1;
            if (exp_v1) begin
                exp_row2  <= exp_q.pop_front();
                exp_mask2 <= mask_q.pop_front();
            end else begin
                exp_row2  <= '0;
                exp_mask2 <= '0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    a_reset_state: assert property (
        @(posedge clk) e_tail_reset |=> (!out_valid && out_row == '0)
    ) else fail_mismatch("out_valid,out_row after reset",
                         {$sampled(out_valid), $sampled(out_row)}, '0);

    a_valid_timing: assert property (
        @(posedge clk) disable iff (e_tail_reset) out_valid == exp_v2
    ) else fail_mismatch("out_valid", $sampled(out_valid), $sampled(exp_v2));

    a_row_value: assert property (
        @(posedge clk) disable iff (e_tail_reset) out_valid |-> out_row == exp_row2
    ) else fail_mismatch("out_row", $sampled(out_row), $sampled(exp_row2));

    // mode 88 drives nothing on the upper channel half
    a_upper_zero: assert property (
        @(posedge clk) disable iff (e_tail_reset)
            (out_valid && model_mode == MODE_88) |-> out_row[127:64] == '0
    ) else fail_mismatch("out_row upper half", $sampled(out_row[127:64]), '0);

    a_clamp_zero: assert property (
        @(posedge clk) disable iff (e_tail_reset) out_valid |-> (out_row & exp_mask2) == '0
    ) else fail_mismatch("out_row clamped lanes", $sampled(out_row & exp_mask2), '0);

    // run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            fail_plain("timeout: run did not finish within the cycle limit");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    function automatic scale_set_t random_set(input mode_e m);
        scale_set_t s;
        s.tail_lo = 16'($urandom);
        s.tail_hi = 16'($urandom);
        // ranks that leave the interesting bits near the bottom
        if (m == MODE_88) begin
            s.rank_lo = 8'($urandom_range(40, 16));
        end else begin
            s.rank_lo = 8'($urandom_range(32, 8));
        end
        s.rank_hi = 8'($urandom_range(32, 8));
        return s;
    endfunction

    function automatic logic [255:0] random_row();
        logic [255:0] r;
        for (int k = 0; k < 8; k++) begin
            r[k*32 +: 32] = $urandom;
        end
        return r;
    endfunction

    // even pixels get bit 7 set, odd ones get it cleared
    function automatic logic [255:0] clamp_row(input mode_e m);
        logic [255:0] r;
        logic [31:0]  word;
        r = '0;
        for (int i = 0; i < 2 * `QT_LANES; i++) begin
            word = $urandom;
            word[7] = (i % 2 == 0);
            if (m == MODE_88 && i < `QT_LANES) begin
                r[i*24 +: 24] = word[23:0];
            end else if (m == MODE_18) begin
                r[i*16 +: 16] = word[15:0];
            end
        end
        return r;
    endfunction

    // every task starts with the clock low and ends on a falling edge
    task automatic apply_reset(input mode_e m);
        e_tail_reset = 1'b1;
        mode_init = m;
        tbl_we = 1'b0;
        in_valid = 1'b0;
        repeat (RESET_CYC) @(negedge clk);
        e_tail_reset = 1'b0;
        model_mode = m;
        for (int i = 0; i < `QT_TABLE_DEPTH; i++) begin
            model_tbl[i] = '0;
        end
    endtask

    task automatic write_entry(input int idx, input scale_set_t s);
        tbl_we = 1'b1;
        tbl_waddr = 4'(idx);
        tbl_tail_lo = s.tail_lo;
        tbl_tail_hi = s.tail_hi;
        tbl_rank_lo = s.rank_lo;
        tbl_rank_hi = s.rank_hi;
        @(negedge clk);
        tbl_we = 1'b0;
        model_tbl[idx] = s;
    endtask

    // select runs one cycle ahead of the row it scales
    task automatic run_burst();
        for (int c = 0; c <= BURST_LEN; c++) begin
            if (c < BURST_LEN) begin
                sel_index = burst_idx[c];
            end else begin
                sel_index = '0;
            end
            if (c > 0) begin
                bias_row = burst_row[c-1];
                in_valid = 1'b1;
                push_expected(burst_row[c-1], model_tbl[burst_idx[c-1]]);
            end else begin
                in_valid = 1'b0;
            end
            @(negedge clk);
        end
        in_valid = 1'b0;
        // let the last row reach the output
        repeat (2) @(negedge clk);
    endtask

    task automatic run_pass(input mode_e m);
        int base;
        apply_reset(m);
        for (int i = 0; i < `QT_TABLE_DEPTH; i++) begin
            write_entry(i, random_set(m));
        end
        // back to back rows with distinct table entries
        repeat (N_BURSTS) begin
            base = $urandom_range(`QT_TABLE_DEPTH - 1, 0);
            for (int k = 0; k < BURST_LEN; k++) begin
                burst_idx[k] = 4'((base + k) % `QT_TABLE_DEPTH);
                burst_row[k] = random_row();
            end
            run_burst();
        end
        // unit tail and zero rank pass the low byte straight to the clamp
        write_entry(CLAMP_IDX, '{tail_hi: 16'd1, tail_lo: 16'd1, rank_hi: 8'd0, rank_lo: 8'd0});
        for (int k = 0; k < BURST_LEN; k++) begin
            burst_idx[k] = 4'(CLAMP_IDX);
            burst_row[k] = clamp_row(m);
        end
        run_burst();
        // same entry before and after a rewrite
        write_entry(REWRITE_IDX, random_set(m));
        for (int k = 0; k < BURST_LEN; k++) begin
            burst_idx[k] = 4'(REWRITE_IDX);
            burst_row[k] = random_row();
        end
        run_burst();
        write_entry(REWRITE_IDX, random_set(m));
        run_burst();
    endtask

    initial begin
        void'($urandom(67770));
        e_tail_reset = 1'b1;
        mode_init = 1'b0;
        tbl_we = 1'b0;
        tbl_waddr = '0;
        tbl_tail_lo = '0;
        tbl_tail_hi = '0;
        tbl_rank_lo = '0;
        tbl_rank_hi = '0;
        sel_index = '0;
        bias_row = '0;
        in_valid = 1'b0;
        model_mode = MODE_88;
        run_pass(MODE_88);
        run_pass(MODE_18);
        repeat (2) @(negedge clk);
        if (clamp_hits == 0 || rows_sent == 0 || exp_q.size() != 0) begin
            fail_plain("clamp lanes never reached or expected rows left unanswered");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

//--- project.f
+incdir+.
quant_pkg.sv
scale_table.sv
e_scale.sv
mult_row.sv
requant_top.sv
tb_clock_gen.sv
tb_requant_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_requant_top
FILELIST  := project.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
